// File: hw/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // Command frame layout is op, then addr, then wdata, sent MSB first
  localparam int ADDR_WIDTH    = 3;
  localparam int DATA_WIDTH    = 8;
  localparam int READ_HDR_BITS = 1 + ADDR_WIDTH; // Op bit plus address
  localparam int CMD_WIDTH     = READ_HDR_BITS + DATA_WIDTH;

  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  typedef struct packed
  {
    spi_op_e                op;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [DATA_WIDTH-1:0]  wdata;
  } spi_cmd_t;

  // One clk wide strobes that line up with the sclk transitions
  typedef struct packed
  {
    logic rise;
    logic fall;
  } spi_edge_t;

  typedef enum logic [2:0]
  {
    IDLE,
    LOAD,
    WR_SHIFT,
    RD_HDR,
    RD_DATA,
    FINISH
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/spi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,
  input  spi_pkg::spi_cmd_t                cmd_in,
  input  logic                             cmd_vld,
  input  spi_pkg::spi_edge_t               edges,
  input  logic [spi_pkg::DATA_WIDTH-1:0]   rx_word,
  output logic                             cmd_rdy,
  output logic                             cs,
  output logic                             run,
  output logic                             load,
  output spi_pkg::spi_cmd_t                frame,
  output logic                             rx_en,
  output logic                             read_vld,
  output logic [spi_pkg::DATA_WIDTH-1:0]   read_data
);
  import spi_pkg::*;

  localparam int BIT_W = $clog2(CMD_WIDTH);
  // Wide enough for any practical sclk divider
  localparam int GAP_W = 16;

  ctrl_state_e       state;
  ctrl_state_e       state_nxt;
  spi_cmd_t          cmd_q;
  logic [BIT_W-1:0]  bit_cnt;
  logic [GAP_W-1:0]  gap_cnt;
  logic [GAP_W-1:0]  half_len;
  logic              accept;
  logic              shifting;
  logic              done;

  assign accept   = cmd_vld && cmd_rdy;
  assign shifting = (state == WR_SHIFT) || (state == RD_HDR) || (state == RD_DATA);
  assign done     = (state == FINISH) && (state_nxt == IDLE);

  assign run   = shifting;
  assign load  = (state == LOAD);
  assign rx_en = (state == RD_DATA);

  // A read only sends its header, so the data field goes out as zeros
  always_comb
  begin
    frame = cmd_q;
    if (cmd_q.op == OP_READ)
      frame.wdata = '0;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (accept)
          state_nxt = LOAD;
      LOAD:
        state_nxt = (cmd_q.op == OP_WRITE) ? WR_SHIFT : RD_HDR;
      WR_SHIFT:
        if (edges.fall && bit_cnt == BIT_W'(CMD_WIDTH - 1))
          state_nxt = FINISH;
      RD_HDR:
        if (edges.fall && bit_cnt == BIT_W'(READ_HDR_BITS - 1))
          state_nxt = RD_DATA;
      RD_DATA:
        if (edges.fall && bit_cnt == BIT_W'(DATA_WIDTH - 1))
          state_nxt = FINISH;
      FINISH:
        if (gap_cnt == half_len)
          state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
      half_len <= '0;
      cs       <= 1'b1;
      cmd_rdy  <= 1'b1;
      read_vld <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state != state_nxt)
        bit_cnt <= '0; // Each phase counts its own bits
      else if (edges.fall)
        bit_cnt <= bit_cnt + 1'b1;
      // The gap between strobes is one half period, reused to time FINISH
      if (edges.rise || edges.fall)
        gap_cnt <= '0;
      else if (state != IDLE)
        gap_cnt <= gap_cnt + 1'b1;
      if (shifting && state_nxt == FINISH)
        half_len <= gap_cnt;
      cs       <= !((state_nxt == WR_SHIFT) || (state_nxt == RD_HDR) || (state_nxt == RD_DATA));
      cmd_rdy  <= (state_nxt == IDLE);
      read_vld <= done && (cmd_q.op == OP_READ);
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (done && cmd_q.op == OP_READ)
      read_data <= rx_word;
  end

  assert property (@(posedge clk) disable iff (!rst_n) shifting |-> !cs)
    else $error("cs high while shifting");
  assert property (@(posedge clk) disable iff (!rst_n) read_vld |-> cmd_q.op == OP_READ)
    else $error("read_vld after a write");
  assert property (@(posedge clk) disable iff (!rst_n) !cs |-> !cmd_rdy)
    else $error("cmd_rdy high during a frame");

endmodule

`default_nettype wire

// File: hw/spi_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_clk_gen #(
  parameter int CLK_DIV = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,
  output logic                sclk,
  output spi_pkg::spi_edge_t  edges
);

  localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [CNT_W-1:0] div_cnt;
  logic             half_done;

  // Last clk of the current half period
  assign half_done = run && (div_cnt == CNT_W'(CLK_DIV - 1));

  assign edges.rise = half_done && !sclk;
  assign edges.fall = half_done && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      sclk    <= 1'b0;
    end
    else if (!run)
    begin
      div_cnt <= '0; // Idle bus parks low for mode 0
      sclk    <= 1'b0;
    end
    else if (half_done)
    begin
      div_cnt <= '0;
      sclk    <= ~sclk;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(edges.rise && edges.fall))
    else $error("rise and fall strobes together");

endmodule

`default_nettype wire

// File: hw/spi_tx_shift.sv
`timescale 1ns/1ps
`default_nettype none

module spi_tx_shift (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  spi_pkg::spi_cmd_t   frame,
  input  spi_pkg::spi_edge_t  edges,
  output logic                mosi
);
  import spi_pkg::*;

  logic [CMD_WIDTH-1:0] tx_q;

  assign mosi = tx_q[CMD_WIDTH-1];

  // Zero fill leaves mosi low once the last bit has gone out
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_q <= '0;
    end
    else if (load)
    begin
      tx_q <= frame;
    end
    else if (edges.fall)
    begin
      tx_q <= {tx_q[CMD_WIDTH-2:0], 1'b0};
    end
  end

  // The strobes only run while cs is low, after the load has happened
  assert property (@(posedge clk) disable iff (!rst_n) load |-> !edges.fall)
    else $error("fall strobe during frame load");

endmodule

`default_nettype wire

// File: hw/spi_rx_shift.sv
`timescale 1ns/1ps
`default_nettype none

module spi_rx_shift (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            rx_en,
  input  spi_pkg::spi_edge_t              edges,
  input  logic                            miso,
  output logic [spi_pkg::DATA_WIDTH-1:0]  rx_word
);
  import spi_pkg::*;

  logic                  rx_en_q;
  logic                  rx_start;
  logic [DATA_WIDTH-1:0] base;

  assign rx_start = rx_en && !rx_en_q;
  // A fresh read phase starts from an empty word even if a bit lands at once
  assign base = rx_start ? '0 : rx_word;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_en_q <= 1'b0;
      rx_word <= '0;
    end
    else
    begin
      rx_en_q <= rx_en;
      if (rx_en && edges.rise)
        rx_word <= {base[DATA_WIDTH-2:0], miso}; // First bit ends up as MSB
      else if (rx_start)
        rx_word <= '0;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !rx_en |=> $stable(rx_word))
    else $error("rx_word changed outside the read phase");

endmodule

`default_nettype wire

// File: hw/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
  parameter int CLK_DIV = 4
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  spi_pkg::spi_cmd_t               cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  output logic                            sclk,
  output logic                            cs,
  output logic                            mosi,
  input  logic                            miso,
  output logic                            read_vld,
  output logic [spi_pkg::DATA_WIDTH-1:0]  read_data
);
  import spi_pkg::*;

  logic                  run;
  logic                  load;
  logic                  rx_en;
  spi_cmd_t              frame;
  spi_edge_t             edges;
  logic [DATA_WIDTH-1:0] rx_word;

  spi_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .edges     (edges),
    .rx_word   (rx_word),
    .cmd_rdy   (cmd_rdy),
    .cs        (cs),
    .run       (run),
    .load      (load),
    .frame     (frame),
    .rx_en     (rx_en),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_clk_gen #(
    .CLK_DIV (CLK_DIV)
  ) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .sclk  (sclk),
    .edges (edges)
  );

  spi_tx_shift u_tx_shift (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .frame (frame),
    .edges (edges),
    .mosi  (mosi)
  );

  spi_rx_shift u_rx_shift (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx_en   (rx_en),
    .edges   (edges),
    .miso    (miso),
    .rx_word (rx_word)
  );

endmodule

`default_nettype wire

// File: verification/spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
  input  logic               sclk,
  input  logic               cs,
  input  logic               mosi,
  output logic               miso,
  output int                 frame_count,
  output int                 bad_count,
  output spi_pkg::spi_cmd_t  last_frame
);
  import spi_pkg::*;

  logic [DATA_WIDTH-1:0]    regs [2**ADDR_WIDTH];
  logic [CMD_WIDTH-1:0]     shift_q;
  logic [READ_HDR_BITS-1:0] hdr;
  spi_cmd_t                 frm;
  int                       bit_cnt;

  initial
  begin
    for (int a = 0; a < 2**ADDR_WIDTH; a++)
      regs[a] = 8'hA0 + 8'(a);
    miso        = 1'b0;
    frame_count = 0;
    bad_count   = 0;
    bit_cnt     = 0;
    hdr         = '0;
    shift_q     = '0;
    last_frame  = '0;
  end

  // Mosi is taken on the rising sclk edge, the frame closes when cs goes high
  always @(posedge sclk or posedge cs)
  begin
    if (cs)
    begin
      if (bit_cnt > 0)
      begin
        frm         = spi_cmd_t'(shift_q);
        last_frame  = frm;
        frame_count = frame_count + 1;
        if (bit_cnt != CMD_WIDTH)
          bad_count = bad_count + 1; // Both frame kinds are 12 clocks long
        else if (frm.op == OP_WRITE)
          regs[frm.addr] = frm.wdata;
      end
      bit_cnt = 0;
    end
    else
    begin
      if (bit_cnt < READ_HDR_BITS)
        hdr = {hdr[READ_HDR_BITS-2:0], mosi};
      shift_q = {shift_q[CMD_WIDTH-2:0], mosi};
      bit_cnt = bit_cnt + 1;
    end
  end

  // Read data goes out MSB first once the header is in
  always @(negedge sclk)
  begin
    if (!cs && !hdr[READ_HDR_BITS-1] && bit_cnt >= READ_HDR_BITS && bit_cnt < CMD_WIDTH)
      miso = regs[hdr[ADDR_WIDTH-1:0]][CMD_WIDTH-1-bit_cnt];
  end

endmodule

`default_nettype wire

// File: verification/tb_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master;
  import spi_pkg::*;

  localparam int CLK_DIV    = 4;
  localparam int PERIOD_NS  = 100;
  localparam int MAX_CASES  = 32;
  localparam int N_RANDOM   = 24;
  localparam int N_REGS     = 2**ADDR_WIDTH;
  localparam int TXN_CYCLES = 2 + 28 * CLK_DIV; // Bound on one command, idle gap included

  logic                  clk;
  logic                  rst_n;
  spi_cmd_t              cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  miso;
  logic                  read_vld;
  logic [DATA_WIDTH-1:0] read_data;
  int                    frame_count;
  int                    bad_count;
  spi_cmd_t              last_frame;

  logic [7:0]            case_mem [4*MAX_CASES];
  logic [DATA_WIDTH-1:0] shadow [N_REGS];
  int                    n_cases;
  int                    errors;
  int                    err_start;
  int                    tests;
  int                    failed;
  int                    seed;
  bit                    loaded;

  spi_master #(
    .CLK_DIV (CLK_DIV)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave_i (
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .miso        (miso),
    .frame_count (frame_count),
    .bad_count   (bad_count),
    .last_frame  (last_frame)
  );

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  task automatic check_read(input spi_cmd_t cmd, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR read_data addr %h: got %h expected %h", cmd.addr, got, exp);
      errors++;
    end
  endtask

  task automatic check_frame(input spi_cmd_t got, input spi_cmd_t exp);
    if (got !== exp)
    begin
      $display("ERROR last_frame: got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pin(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_idle();
    check_pin("cs", cs, 1'b1);
    check_pin("sclk", sclk, 1'b0);
    check_pin("mosi", mosi, 1'b0);
    check_pin("cmd_rdy", cmd_rdy, 1'b1);
    check_pin("read_vld", read_vld, 1'b0);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != err_start)
      failed++;
    $display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "failed");
    err_start = errors;
  endtask

  // With poke set, a second command is offered while the first one is still running
  task automatic run_cmd(input spi_cmd_t cmd, input bit poke,
                         output logic [DATA_WIDTH-1:0] data, output int pulses);
    int       cycles;
    spi_cmd_t bogus;
    bogus       = cmd;
    bogus.op    = OP_WRITE;
    bogus.wdata = ~cmd.wdata;
    pulses      = 0;
    data        = '0;
    cycles      = 0;
    @(negedge clk);
    while (!cmd_rdy && cycles < TXN_CYCLES)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!cmd_rdy)
    begin
      $display("cmd_rdy stayed low, the command could not be issued");
      errors++;
      return;
    end
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    cycles  = 0;
    while (!cmd_rdy && cycles < TXN_CYCLES)
    begin
      @(negedge clk);
      cycles++;
      if (poke)
      begin
        cmd_in  = bogus;
        cmd_vld = (cycles == 6);
      end
      if (read_vld)
      begin
        pulses++;
        data = read_data;
      end
    end
    cmd_vld = 1'b0;
    if (!cmd_rdy)
    begin
      $display("Command did not finish, cmd_rdy never came back");
      errors++;
    end
    @(negedge clk);
    if (read_vld)
      pulses++;
  endtask

  task automatic apply_cmd(input spi_cmd_t cmd, input logic [DATA_WIDTH-1:0] exp, input bit poke);
    spi_cmd_t              sent;
    logic [DATA_WIDTH-1:0] data;
    int                    pulses;
    int                    frames;
    sent = cmd;
    if (cmd.op == OP_READ)
      sent.wdata = '0; // Only the header carries meaning on a read
    frames = frame_count;
    run_cmd(cmd, poke, data, pulses);
    check_count("frame_count", frame_count, frames + 1);
    check_count("bad_count", bad_count, 0);
    check_frame(last_frame, sent);
    if (cmd.op == OP_READ)
    begin
      check_count("read_vld pulses", pulses, 1);
      check_read(cmd, data, exp);
    end
    else
    begin
      check_count("read_vld pulses", pulses, 0);
      shadow[cmd.addr] = cmd.wdata;
    end
    check_idle();
  endtask

  initial
  begin
    spi_cmd_t    cmd;
    logic [31:0] rnd;
    seed      = 32'h125;
    errors    = 0;
    err_start = 0;
    tests     = 0;
    failed    = 0;
    rst_n     = 1'b0;
    cmd_vld   = 1'b0;
    cmd_in    = '0;
    for (int i = 0; i < 4*MAX_CASES; i++)
      case_mem[i] = {1'b1, 7'(i)}; // Never a legal op, so it marks the end of the cases
    $readmemh("verification/spi_cases.txt", case_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && case_mem[4*n_cases] <= 8'h01)
      n_cases++;
    for (int a = 0; a < N_REGS; a++)
      shadow[a] = 8'hA0 + 8'(a);
    loaded = 1'b1;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_idle();
    end_test("reset idle");

    if (n_cases == 0)
    begin
      $display("No cases could be read from verification/spi_cases.txt");
      errors++;
    end
    for (int i = 0; i < n_cases; i++)
    begin
      cmd.op    = spi_op_e'(case_mem[4*i][0]);
      cmd.addr  = case_mem[4*i+1][ADDR_WIDTH-1:0];
      cmd.wdata = case_mem[4*i+2];
      apply_cmd(cmd, case_mem[4*i+3], 1'b0);
      end_test($sformatf("case %0d", i));
    end

    // The poked write would store the inverted value if it were taken
    cmd = '{op: OP_WRITE, addr: 3'd2, wdata: 8'h3C};
    apply_cmd(cmd, 8'h00, 1'b1);
    cmd = '{op: OP_READ, addr: 3'd2, wdata: 8'h00};
    apply_cmd(cmd, 8'h3C, 1'b0);
    end_test("busy drop");

    for (int n = 0; n < N_RANDOM; n++)
    begin
      rnd       = $random(seed);
      cmd.op    = spi_op_e'(rnd[0]);
      cmd.addr  = rnd[10:8];
      cmd.wdata = rnd[23:16];
      apply_cmd(cmd, shadow[cmd.addr], 1'b0);
    end
    end_test("random");

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    longint limit_ns;
    wait (loaded);
    limit_ns = (longint'(n_cases + N_RANDOM + 2) * TXN_CYCLES + 16 + 200) * PERIOD_NS;
    #(limit_ns);
    $display("Watchdog expired after %0d ns, the run did not complete", limit_ns);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/spi_pkg.sv
hw/spi_ctrl.sv
hw/spi_clk_gen.sv
hw/spi_tx_shift.sv
hw/spi_rx_shift.sv
hw/spi_master.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

// File: Makefile
# Verilator build and run for the SPI master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the result"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/spi_cases.txt
// Columns: op addr wdata expected, all hex
// op 1 writes wdata to addr, op 0 reads addr and expects the last column
0 0 00 A0
0 5 00 A5
1 3 5A 00
0 3 00 5A
0 2 00 A2
0 4 00 A4
1 0 FF 00
1 7 01 00
0 0 00 FF
0 7 00 01
0 6 00 A6
1 3 C3 00
0 3 00 C3
1 5 00 00
0 5 00 00
0 1 00 A1
0 4 00 A4
